// File: dv/dec_tb.sv
//**************************************
// decode block testbench
// table stimulus, reference decoder,
// register model and trace check
//**************************************

module dec_tb;

   localparam int IB_DEPTH   = 4;
   localparam int NROWS      = 32;
   localparam int MAX_CYCLES = 8 * NROWS + 50;           // reset, table and drain

   // one stimulus row, one clock cycle
   typedef struct packed {
      dec_pkg::fetch_pkt_t  f0;
      dec_pkg::fetch_pkt_t  f1;
      dec_pkg::wb_pkt_t     w0;
      dec_pkg::wb_pkt_t     w1;
      dec_pkg::wb_pkt_t     wn;                          // non-blocking load port
      dec_pkg::retire_pkt_t r0;
      dec_pkg::retire_pkt_t r1;
      logic                 stall;
      logic                 flush;
   } row_t;

   logic                     clk = 1'b0;
   logic                     rst_n;
   row_t                     drv;                        // inputs driven now
   logic                     ib_full;
   dec_pkg::dec_pkt_t        dec_i0_pkt;
   dec_pkg::dec_pkt_t        dec_i1_pkt;
   logic [dec_pkg::XLEN-1:0] gpr_i0_rs1_d;
   logic [dec_pkg::XLEN-1:0] gpr_i0_rs2_d;
   logic [dec_pkg::XLEN-1:0] gpr_i1_rs1_d;
   logic [dec_pkg::XLEN-1:0] gpr_i1_rs2_d;
   dec_pkg::trace_pkt_t      trace_pkt;

   dec_pkg::fetch_pkt_t      exp_q [$];                  // pushed, not yet issued
   logic [dec_pkg::XLEN-1:0] regs [32];                  // register model
   dec_pkg::retire_pkt_t     last_r0;
   dec_pkg::retire_pkt_t     last_r1;
   row_t                     tbl [NROWS];
   integer                   seed = 32'h8480;
   int                       cycle_cnt = 0;

   dec #(.IB_DEPTH(IB_DEPTH)) dec_inst (
      .clk, .rst_n,
      .flush(drv.flush), .dec_stall(drv.stall),
      .fetch_i0(drv.f0), .fetch_i1(drv.f1),
      .wb_i0(drv.w0), .wb_i1(drv.w1), .wb_nbload(drv.wn),
      .retire_i0(drv.r0), .retire_i1(drv.r1),
      .ib_full, .dec_i0_pkt, .dec_i1_pkt,
      .gpr_i0_rs1_d, .gpr_i0_rs2_d, .gpr_i1_rs1_d, .gpr_i1_rs2_d,
      .trace_pkt
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run still going after %0d cycles", cycle_cnt);
         stop_with_fail();
      end
   end

   task automatic stop_with_fail();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   //**************************************
   // compare tasks
   //**************************************
   // an idle slot only has to show valid low
   task automatic check_dec_pkt(input dec_pkg::dec_pkt_t got, input dec_pkg::dec_pkt_t exp,
                                input string what);
      if ((got.valid !== exp.valid) || (exp.valid && (got !== exp))) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic check_data(input logic [dec_pkg::XLEN-1:0] got,
                             input logic [dec_pkg::XLEN-1:0] exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         stop_with_fail();
      end
   endtask

   task automatic check_trace(input dec_pkg::trace_pkt_t got, input dec_pkg::trace_pkt_t exp,
                              input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         stop_with_fail();
      end
   endtask

   //**************************************
   // reference model
   //**************************************
   function automatic logic [31:0] sext(input logic [31:0] v, input int w);
      logic [31:0] r;
      r = v;
      for (int b = w; b < 32; b++) begin
         r[b] = v[w-1];                                  // copy sign upward
      end
      return r;
   endfunction

   function automatic dec_pkg::dec_pkt_t expect_decode(input dec_pkg::fetch_pkt_t f);
      dec_pkg::dec_pkt_t e;
      logic [31:0]       i;
      i       = f.instr;
      e       = '0;
      e.valid = 1'b1;
      e.legal = 1'b1;
      e.pc    = f.pc;
      e.instr = i;
      e.rs1   = i[19:15];
      e.rs2   = i[24:20];
      e.rd    = i[11:7];
      case (i[6:0])
         dec_pkg::OPC_LUI, dec_pkg::OPC_AUIPC: e.imm = {i[31:12], 12'h000};
         dec_pkg::OPC_JAL: e.imm = sext(32'({i[31], i[19:12], i[20], i[30:21], 1'b0}), 21);
         dec_pkg::OPC_JALR, dec_pkg::OPC_LOAD, dec_pkg::OPC_OP_IMM: e.imm = sext(32'(i[31:20]), 12);
         dec_pkg::OPC_BRANCH: e.imm = sext(32'({i[31], i[7], i[30:25], i[11:8], 1'b0}), 13);
         dec_pkg::OPC_STORE: e.imm = sext(32'({i[31:25], i[11:7]}), 12);
         dec_pkg::OPC_OP: e.imm = '0;                    // register form
         default: e.legal = 1'b0;
      endcase
      e.rs1_en = e.legal &&
                 !(i[6:0] inside {dec_pkg::OPC_LUI, dec_pkg::OPC_AUIPC, dec_pkg::OPC_JAL});
      e.rs2_en = i[6:0] inside {dec_pkg::OPC_BRANCH, dec_pkg::OPC_STORE, dec_pkg::OPC_OP};
      e.rd_en  = e.legal && !(i[6:0] inside {dec_pkg::OPC_BRANCH, dec_pkg::OPC_STORE}) &&
                 (e.rd != 5'd0);
      return e;
   endfunction

   function automatic dec_pkg::trace_pkt_t expect_trace(input dec_pkg::retire_pkt_t r0,
                                                        input dec_pkg::retire_pkt_t r1);
      dec_pkg::trace_pkt_t t;
      t.valid = {r1.valid, r0.valid};
      t.insn  = {r1.instr, r0.instr};
      t.addr  = {r1.pc, 1'b0, r0.pc, 1'b0};
      return t;
   endfunction

   function automatic logic [31:0] read_ref(input logic en, input logic [4:0] a);
      return en ? regs[a] : 32'h0;                       // x0 never written
   endfunction

   task automatic write_ref(input dec_pkg::wb_pkt_t w);
      if (w.en && (w.addr != 5'd0)) begin
         regs[w.addr] = w.data;
      end
   endtask

   //**************************************
   // stimulus table
   //**************************************
   function automatic logic [6:0] pick_opcode(input int n);
      case (n % 10)
         0: return dec_pkg::OPC_LUI;
         1: return dec_pkg::OPC_AUIPC;
         2: return dec_pkg::OPC_JAL;
         3: return dec_pkg::OPC_JALR;
         4: return dec_pkg::OPC_BRANCH;
         5: return dec_pkg::OPC_LOAD;
         6: return dec_pkg::OPC_STORE;
         7: return dec_pkg::OPC_OP_IMM;
         8: return dec_pkg::OPC_OP;
         default: return 7'b1111111;                     // not an RV32I opcode
      endcase
   endfunction

   function automatic logic [31:0] random_instr(input int n);
      logic [31:0] i;
      i        = $random(seed);
      i[6:0]   = pick_opcode(n);
      i[11:10] = 2'b00;                                  // registers in x0..x7
      i[19:18] = 2'b00;
      i[24:23] = 2'b00;
      return i;
   endfunction

   function automatic dec_pkg::wb_pkt_t random_write();
      dec_pkg::wb_pkt_t w;
      logic [31:0]      rnd;
      rnd    = $random(seed);
      w.en   = rnd[0];
      w.addr = {2'b00, rnd[3:1]};                        // frequent address clashes
      w.data = $random(seed);
      return w;
   endfunction

   function automatic dec_pkg::retire_pkt_t random_retire();
      dec_pkg::retire_pkt_t r;
      logic [31:0]          rnd;
      rnd     = $random(seed);
      r.valid = rnd[0];
      r.instr = $random(seed);
      r.pc    = rnd[31:1];
      return r;
   endfunction

   task automatic build_table();
      logic [31:0] pc;
      pc = 32'h0000_1000;
      for (int k = 0; k < NROWS; k++) begin
         tbl[k]          = '0;
         tbl[k].f0.valid = (k < 24) && (k % 6 != 5);     // last rows drain
         tbl[k].f1.valid = tbl[k].f0.valid && (k % 4 != 3);
         tbl[k].f0.instr = random_instr(2 * k);
         tbl[k].f1.instr = random_instr(2 * k + 1);
         tbl[k].f0.pc    = pc[31:1];
         tbl[k].f1.pc    = pc[31:1] + 31'd2;
         pc              = pc + 32'd8;
         tbl[k].stall    = ((k >= 8) && (k < 12)) || (k == 17);
         tbl[k].flush    = (k == 14);
         tbl[k].w0       = random_write();
         tbl[k].w1       = random_write();
         tbl[k].wn       = random_write();
         tbl[k].r0       = random_retire();
         tbl[k].r1       = random_retire();
      end
      // independent pair into an empty buffer
      tbl[0].f0.instr = {12'h005, 5'd2, 3'b000, 5'd1, dec_pkg::OPC_OP_IMM};  // addi x1,x2,5
      tbl[0].f1.instr = {7'h00, 5'd5, 5'd4, 3'b000, 5'd3, dec_pkg::OPC_OP};  // add x3,x4,x5
      // slot 1 needs slot 0 result
      tbl[1].f0.instr = {7'h20, 5'd2, 5'd0, 3'b000, 5'd6, dec_pkg::OPC_OP};  // sub x6,x0,x2
      tbl[1].f1.instr = {7'h00, 5'd3, 5'd6, 3'b001, 5'h08, dec_pkg::OPC_BRANCH};
      // i0 over load on x3 read by the branch
      tbl[1].wn = {1'b1, 5'd3, 32'h4444_4444};
      tbl[1].w0 = {1'b1, 5'd3, 32'h5555_5555};
      tbl[1].w1 = {1'b1, 5'd0, 32'hdead_beef};           // sub reads x0 next
      // i1 over i0 over load on x6 before the branch issues
      tbl[2].wn = {1'b1, 5'd6, 32'h1111_1111};
      tbl[2].w0 = {1'b1, 5'd6, 32'h2222_2222};
      tbl[2].w1 = {1'b1, 5'd6, 32'h3333_3333};
   endtask

   //**************************************
   // one cycle: drive, check, advance model
   //**************************************
   task automatic run_row(input row_t r);
      row_t              d;
      dec_pkg::dec_pkt_t e0;
      dec_pkg::dec_pkt_t e1;
      dec_pkg::dec_pkt_t t;
      d = r;
      if (exp_q.size() > IB_DEPTH - 2) begin             // fetch holds off while full
         d.f0.valid = 1'b0;
         d.f1.valid = 1'b0;
      end
      @(posedge clk);
      #2 drv = d;
      @(negedge clk);
      check_data(32'(ib_full), 32'(exp_q.size() > IB_DEPTH - 2), "ib_full");
      e0 = '0;
      e1 = '0;
      if ((exp_q.size() > 0) && !d.stall) begin
         e0 = expect_decode(exp_q[0]);
      end
      if (e0.valid && (exp_q.size() > 1)) begin
         t = expect_decode(exp_q[1]);
         if (!(e0.rd_en && ((t.rs1_en && (t.rs1 == e0.rd)) || (t.rs2_en && (t.rs2 == e0.rd)))))
            e1 = t;                                      // no hazard, dual issue
      end
      check_dec_pkt(dec_i0_pkt, e0, "slot 0 decode");
      check_dec_pkt(dec_i1_pkt, e1, "slot 1 decode");
      if (e0.valid) begin
         check_data(gpr_i0_rs1_d, read_ref(e0.rs1_en, e0.rs1), "slot 0 rs1 data");
         check_data(gpr_i0_rs2_d, read_ref(e0.rs2_en, e0.rs2), "slot 0 rs2 data");
      end
      if (e1.valid) begin
         check_data(gpr_i1_rs1_d, read_ref(e1.rs1_en, e1.rs1), "slot 1 rs1 data");
         check_data(gpr_i1_rs2_d, read_ref(e1.rs2_en, e1.rs2), "slot 1 rs2 data");
      end
      check_trace(trace_pkt, expect_trace(last_r0, last_r1), "trace packet");
      if (e0.valid) void'(exp_q.pop_front());
      if (e1.valid) void'(exp_q.pop_front());
      if (d.flush) begin
         exp_q.delete();                                 // same-cycle pushes dropped too
      end else begin
         if (d.f0.valid) exp_q.push_back(d.f0);
         if (d.f1.valid) exp_q.push_back(d.f1);
      end
      write_ref(d.wn);                                   // later call wins
      write_ref(d.w0);
      write_ref(d.w1);
      last_r0 = d.r0;
      last_r1 = d.r1;
   endtask

   initial begin
      rst_n   = 1'b0;
      drv     = '0;
      last_r0 = '0;
      last_r1 = '0;
      // busy inputs while in reset, all of it must be ignored
      drv.f0.valid = 1'b1;
      drv.f1.valid = 1'b1;
      drv.w0       = {1'b1, 5'd2, 32'hffff_ffff};
      drv.w1       = {1'b1, 5'd4, 32'hffff_ffff};
      drv.wn       = {1'b1, 5'd5, 32'hffff_ffff};
      drv.r0.valid = 1'b1;                               // payload stays zero
      drv.r1.valid = 1'b1;
      for (int a = 0; a < 32; a++) begin
         regs[a] = '0;
      end
      build_table();
      for (int c = 0; c < 8; c++) begin
         @(posedge clk);
         if (c == 7) begin
            #2;
            rst_n = 1'b1;                                // last check is right after reset
            drv   = '0;                                  // quiet before the table
         end
         @(negedge clk);
         check_data(32'(ib_full), 32'h0, "ib_full in reset");
         check_dec_pkt(dec_i0_pkt, '0, "slot 0 in reset");
         check_dec_pkt(dec_i1_pkt, '0, "slot 1 in reset");
         check_trace(trace_pkt, '0, "trace in reset");
      end
      for (int k = 0; k < NROWS; k++) begin
         run_row(tbl[k]);
      end
      while (exp_q.size() != 0) begin                    // drain, cycle limit guards
         run_row('0);
      end
      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: flist.f
hw/dec_pkg.sv
hw/dec_ib_ctl.sv
hw/dec_decode_ctl.sv
hw/dec_gpr_ctl.sv
hw/dec_trace.sv
hw/dec.sv
dv/dec_tb.sv

// File: hw/dec.sv
//**************************************
// dual-slot decode top
// buffer, decode, register file, trace
//**************************************

module dec #(
   parameter int IB_DEPTH = 4                            // instruction buffer depth
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      dec_stall,
   input  dec_pkg::fetch_pkt_t       fetch_i0,
   input  dec_pkg::fetch_pkt_t       fetch_i1,
   input  dec_pkg::wb_pkt_t          wb_i0,
   input  dec_pkg::wb_pkt_t          wb_i1,
   input  dec_pkg::wb_pkt_t          wb_nbload,
   input  dec_pkg::retire_pkt_t      retire_i0,
   input  dec_pkg::retire_pkt_t      retire_i1,
   output logic                      ib_full,            // to fetch
   output dec_pkg::dec_pkt_t         dec_i0_pkt,
   output dec_pkg::dec_pkt_t         dec_i1_pkt,
   output logic [dec_pkg::XLEN-1:0]  gpr_i0_rs1_d,
   output logic [dec_pkg::XLEN-1:0]  gpr_i0_rs2_d,
   output logic [dec_pkg::XLEN-1:0]  gpr_i1_rs1_d,
   output logic [dec_pkg::XLEN-1:0]  gpr_i1_rs2_d,
   output dec_pkg::trace_pkt_t       trace_pkt
);

   dec_pkg::fetch_pkt_t ib_head0;                        // oldest entry
   dec_pkg::fetch_pkt_t ib_head1;
   logic [1:0]          issue_cnt;                       // pops this cycle

   dec_ib_ctl #(.IB_DEPTH(IB_DEPTH)) instbuff (
      .clk, .rst_n, .flush,
      .fetch_i0, .fetch_i1,
      .issue_cnt,
      .ib_full,
      .ib_head0, .ib_head1
   );

   dec_decode_ctl decode (
      .ib_head0, .ib_head1,
      .dec_stall,
      .issue_cnt,
      .dec_i0_pkt, .dec_i1_pkt
   );

   // read ports follow the decoded source fields
   dec_gpr_ctl arf (
      .clk, .rst_n,
      .raddr0(dec_i0_pkt.rs1), .rden0(dec_i0_pkt.rs1_en),
      .raddr1(dec_i0_pkt.rs2), .rden1(dec_i0_pkt.rs2_en),
      .raddr2(dec_i1_pkt.rs1), .rden2(dec_i1_pkt.rs1_en),
      .raddr3(dec_i1_pkt.rs2), .rden3(dec_i1_pkt.rs2_en),
      .wb_i0, .wb_i1, .wb_nbload,
      .rd0(gpr_i0_rs1_d), .rd1(gpr_i0_rs2_d),
      .rd2(gpr_i1_rs1_d), .rd3(gpr_i1_rs2_d)
   );

   dec_trace trace (
      .clk, .rst_n,
      .retire_i0, .retire_i1,
      .trace_pkt
   );

endmodule

// File: hw/dec_decode_ctl.sv
//**************************************
// decode control
// RV32I field and immediate decode for
// both head slots, single or dual issue
//**************************************

module dec_decode_ctl (
   input  dec_pkg::fetch_pkt_t ib_head0,
   input  dec_pkg::fetch_pkt_t ib_head1,
   input  logic                dec_stall,                // hold everything
   output logic [1:0]          issue_cnt,                // entries to pop
   output dec_pkg::dec_pkt_t   dec_i0_pkt,
   output dec_pkg::dec_pkt_t   dec_i1_pkt
);

   dec_pkg::dec_pkt_t d0;                                // raw slot 0 decode
   dec_pkg::dec_pkt_t d1;                                // raw slot 1 decode
   logic              raw_hit;                           // slot 1 reads slot 0 rd
   logic              i0_go;
   logic              i1_go;

   //**************************************
   // per-slot decode
   //**************************************
   function automatic dec_pkg::dec_pkt_t decode_slot(input dec_pkg::fetch_pkt_t f);
      dec_pkg::dec_pkt_t d;
      logic [31:0]       i;
      i       = f.instr;
      d       = '0;
      d.valid = f.valid;
      d.pc    = f.pc;
      d.instr = i;
      d.rs1   = i[19:15];                                // raw fields always
      d.rs2   = i[24:20];
      d.rd    = i[11:7];
      d.legal = 1'b1;
      case (i[6:0])
         dec_pkg::OPC_LUI, dec_pkg::OPC_AUIPC: begin
            d.rd_en = 1'b1;
            d.imm   = {i[31:12], 12'b0};                 // U
         end
         dec_pkg::OPC_JAL: begin
            d.rd_en = 1'b1;
            d.imm   = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0}; // J
         end
         dec_pkg::OPC_JALR, dec_pkg::OPC_LOAD, dec_pkg::OPC_OP_IMM: begin
            d.rd_en  = 1'b1;
            d.rs1_en = 1'b1;
            d.imm    = {{20{i[31]}}, i[31:20]};          // I
         end
         dec_pkg::OPC_BRANCH: begin
            d.rs1_en = 1'b1;
            d.rs2_en = 1'b1;
            d.imm    = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0}; // B
         end
         dec_pkg::OPC_STORE: begin
            d.rs1_en = 1'b1;
            d.rs2_en = 1'b1;
            d.imm    = {{20{i[31]}}, i[31:25], i[11:7]}; // S
         end
         dec_pkg::OPC_OP: begin
            d.rd_en  = 1'b1;
            d.rs1_en = 1'b1;
            d.rs2_en = 1'b1;                             // no immediate
         end
         default: begin
            d.legal = 1'b0;                              // enables stay low
         end
      endcase
      d.rd_en = d.rd_en & (d.rd != '0);                  // x0 writes are no-ops
      return d;
   endfunction

   assign d0 = decode_slot(ib_head0);
   assign d1 = decode_slot(ib_head1);

   //**************************************
   // issue
   //**************************************
   assign raw_hit = d0.rd_en & ((d1.rs1_en & (d1.rs1 == d0.rd)) |
                                (d1.rs2_en & (d1.rs2 == d0.rd)));

   assign i0_go = d0.valid & ~dec_stall;
   assign i1_go = i0_go & d1.valid & ~raw_hit;           // in order behind slot 0

   assign issue_cnt = {1'b0, i0_go} + {1'b0, i1_go};

   always_comb begin
      dec_i0_pkt       = d0;
      dec_i0_pkt.valid = i0_go;
      dec_i1_pkt       = d1;
      dec_i1_pkt.valid = i1_go;
   end

endmodule

// File: hw/dec_gpr_ctl.sv
//**************************************
// architectural register file
// 4 async reads, 3 prioritized writes
//**************************************

module dec_gpr_ctl (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [dec_pkg::GPR_ADDR_W-1:0] raddr0,
   input  logic [dec_pkg::GPR_ADDR_W-1:0] raddr1,
   input  logic [dec_pkg::GPR_ADDR_W-1:0] raddr2,
   input  logic [dec_pkg::GPR_ADDR_W-1:0] raddr3,
   input  logic                           rden0,
   input  logic                           rden1,
   input  logic                           rden2,
   input  logic                           rden3,
   input  dec_pkg::wb_pkt_t               wb_i0,
   input  dec_pkg::wb_pkt_t               wb_i1,
   input  dec_pkg::wb_pkt_t               wb_nbload,   // non-blocking load return
   output logic [dec_pkg::XLEN-1:0]       rd0,
   output logic [dec_pkg::XLEN-1:0]       rd1,
   output logic [dec_pkg::XLEN-1:0]       rd2,
   output logic [dec_pkg::XLEN-1:0]       rd3
);

   localparam int NREGS = 2 ** dec_pkg::GPR_ADDR_W;

   logic [dec_pkg::XLEN-1:0] gpr_q [NREGS];              // entry 0 stays zero
   dec_pkg::wb_pkt_t         wr_port [3];                // lowest priority first

   assign wr_port[0] = wb_nbload;
   assign wr_port[1] = wb_i0;
   assign wr_port[2] = wb_i1;                            // wins same address

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int r = 0; r < NREGS; r++) begin
            gpr_q[r] <= '0;
         end
      end else begin
         for (int p = 0; p < 3; p++) begin               // later port overrides
            if (wr_port[p].en && (wr_port[p].addr != '0)) begin
               gpr_q[wr_port[p].addr] <= wr_port[p].data;
            end
         end
      end
   end

   // disabled port reads zero
   assign rd0 = rden0 ? gpr_q[raddr0] : '0;
   assign rd1 = rden1 ? gpr_q[raddr1] : '0;
   assign rd2 = rden2 ? gpr_q[raddr2] : '0;
   assign rd3 = rden3 ? gpr_q[raddr3] : '0;

endmodule

// File: hw/dec_ib_ctl.sv
//**************************************
// instruction buffer
// circular queue, up to two pushes and
// two pops a cycle, oldest two at the head
//**************************************

module dec_ib_ctl #(
   parameter int IB_DEPTH = 4                            // even, 4 or more
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flush,                    // empties the queue
   input  dec_pkg::fetch_pkt_t fetch_i0,
   input  dec_pkg::fetch_pkt_t fetch_i1,
   input  logic [1:0]          issue_cnt,                // pops from decode
   output logic                ib_full,
   output dec_pkg::fetch_pkt_t ib_head0,
   output dec_pkg::fetch_pkt_t ib_head1
);

   localparam int PTR_W = $clog2(IB_DEPTH);
   localparam int CNT_W = $clog2(IB_DEPTH + 1);

   dec_pkg::fetch_pkt_t ib_q [IB_DEPTH];                 // queue storage

   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W-1:0] rd_ptr_d;
   logic [PTR_W-1:0] rd_ptr_p1;                          // second oldest
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] wr_ptr_d;
   logic [PTR_W-1:0] wr_ptr_p1;                          // slot 1 landing spot
   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] cnt_d;
   logic             push0;
   logic             push1;
   logic [1:0]       push_cnt;
   logic             full_q;

   // wrapping pointer add, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input logic [1:0]       n);
      logic [PTR_W:0] sum;
      sum = {1'b0, ptr} + (PTR_W + 1)'(n);
      if (sum >= (PTR_W + 1)'(IB_DEPTH)) begin
         sum = sum - (PTR_W + 1)'(IB_DEPTH);             // wrap
      end
      return sum[PTR_W-1:0];
   endfunction

   //**************************************
   // push / pop bookkeeping
   //**************************************
   // slot 1 only ever rides along with slot 0
   assign push0    = fetch_i0.valid & ~full_q & ~flush;
   assign push1    = fetch_i1.valid & fetch_i0.valid & ~full_q & ~flush;
   assign push_cnt = {1'b0, push0} + {1'b0, push1};

   assign rd_ptr_p1 = ptr_add(rd_ptr_q, 2'd1);
   assign wr_ptr_p1 = ptr_add(wr_ptr_q, 2'd1);

   assign rd_ptr_d = flush ? '0 : ptr_add(rd_ptr_q, issue_cnt);
   assign wr_ptr_d = flush ? '0 : ptr_add(wr_ptr_q, push_cnt);
   assign cnt_d    = flush ? '0 : cnt_q - CNT_W'(issue_cnt) + CNT_W'(push_cnt);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         cnt_q    <= '0;
         full_q   <= 1'b0;
      end else begin
         rd_ptr_q <= rd_ptr_d;
         wr_ptr_q <= wr_ptr_d;
         cnt_q    <= cnt_d;
         full_q   <= (cnt_d > CNT_W'(IB_DEPTH - 2));     // under two free slots
      end
   end

   // storage writes, payload only
   always_ff @(posedge clk) begin
      if (push0) begin
         ib_q[wr_ptr_q] <= fetch_i0;
      end
      if (push1) begin
         ib_q[wr_ptr_p1] <= fetch_i1;
      end
   end

   //**************************************
   // head presentation
   //**************************************
   always_comb begin
      ib_head0       = ib_q[rd_ptr_q];
      ib_head0.valid = (cnt_q != '0);                    // valid from occupancy
      ib_head1       = ib_q[rd_ptr_p1];
      ib_head1.valid = (cnt_q > CNT_W'(1));
   end

   assign ib_full = full_q;

endmodule

// File: hw/dec_pkg.sv
//**************************************
// decode package
// widths, RV32I major opcodes and the
// packets shared across the decode block
//**************************************

package dec_pkg;

   localparam int XLEN       = 32;                      // integer data width
   localparam int GPR_ADDR_W = 5;                       // x0..x31

   //**************************************
   // major opcodes, instr[6:0]
   //**************************************
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   //**************************************
   // packets
   //**************************************

   // one fetched instruction
   typedef struct packed {
      logic         valid;
      logic [31:0]  instr;
      logic [31:1]  pc;                                  // halfword aligned pc
   } fetch_pkt_t;

   // one decoded instruction
   typedef struct packed {
      logic                  valid;                      // issued this cycle
      logic                  legal;                      // known opcode
      logic [GPR_ADDR_W-1:0] rs1;
      logic                  rs1_en;
      logic [GPR_ADDR_W-1:0] rs2;
      logic                  rs2_en;
      logic [GPR_ADDR_W-1:0] rd;
      logic                  rd_en;                      // never set for x0
      logic [XLEN-1:0]       imm;                        // format immediate
      logic [31:1]           pc;
      logic [31:0]           instr;
   } dec_pkt_t;

   // one register write
   typedef struct packed {
      logic                  en;
      logic [GPR_ADDR_W-1:0] addr;
      logic [XLEN-1:0]       data;
   } wb_pkt_t;

   // one retiring instruction
   typedef struct packed {
      logic         valid;
      logic [31:0]  instr;
      logic [31:1]  pc;
   } retire_pkt_t;

   // trace port, slot 1 in the upper halves
   typedef struct packed {
      logic [1:0]   valid;                               // bit 0 is slot 0
      logic [63:0]  insn;
      logic [63:0]  addr;                                // pc with bit 0 zero
   } trace_pkt_t;

endpackage

// File: hw/dec_trace.sv
//**************************************
// retire trace
// one cycle register into trace packet
//**************************************

module dec_trace (
   input  logic                 clk,
   input  logic                 rst_n,
   input  dec_pkg::retire_pkt_t retire_i0,
   input  dec_pkg::retire_pkt_t retire_i1,
   output dec_pkg::trace_pkt_t  trace_pkt
);

   logic        vld0_q;                                  // slot 0 retired
   logic        vld1_q;
   logic [31:0] instr0_q;
   logic [31:0] instr1_q;
   logic [31:1] pc0_q;
   logic [31:1] pc1_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld0_q <= 1'b0;
         vld1_q <= 1'b0;
      end else begin
         vld0_q <= retire_i0.valid;
         vld1_q <= retire_i1.valid;
      end
   end

   // payload follows the inputs every cycle
   always_ff @(posedge clk) begin
      instr0_q <= retire_i0.instr;
      instr1_q <= retire_i1.instr;
      pc0_q    <= retire_i0.pc;
      pc1_q    <= retire_i1.pc;
   end

   assign trace_pkt.valid = {vld1_q, vld0_q};
   assign trace_pkt.insn  = {instr1_q, instr0_q};        // slot 1 high
   assign trace_pkt.addr  = {pc1_q, 1'b0, pc0_q, 1'b0};  // byte addresses

endmodule

// File: run.sh
#!/bin/sh
# build and run the decode testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module dec_tb -f flist.f -o Vdec_tb
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/Vdec_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
   echo "simulation failed"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

echo "simulation passed"
exit 0
